/* filelist.f */
+incdir+common
common/pi_pkg.sv
rtl/pi_bus_events.sv
decode/window_match.sv
decode/window_select.sv
rtl/pi_fifo.sv
rtl/pi_data_path.sv
rtl/pi_bridge_top.sv
bench/mem_bus_model.sv
bench/pi_bridge_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal
TOP       ?= pi_bridge_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Done: errors found

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	if [ $$status -ne 0 ]; then exit $$status; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/pi_bridge_tb.sv */
`timescale 1ns/1ps
`include "pi_params.svh"

module pi_bridge_tb;
    import pi_pkg::*;

    localparam int ROWS = 9;
    localparam int PHASE = 40;

    typedef struct packed {
        logic [3:0] enables;
        logic run;
        logic [31:0] addr;
        logic is_write;
        logic to_reg;
        logic quiet;
        logic [1:0] words;
        logic [47:0] data;
        logic [31:0] exp_mem;
    } row_t;

    logic clk;
    logic pi_reset;
    logic n64_reset;
    logic alel;
    logic aleh;
    logic rd;
    logic wr;
    logic [`PI_WINDOWS-1:0] window_enable;
    logic [15:0] ad_drv;
    logic ad_oe;
    wire [15:0] n64_pi_ad;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;
    reg_addr_t reg_address;
    logic reg_read;
    logic reg_write;
    pi_word_t reg_wdata;
    pi_word_t reg_rdata;
    mem_addr_t last_address;

    row_t table_rows [ROWS];
    int errors;
    int checks;
    int mem_acks;
    int reg_reads;
    int pad_cycles;
    mem_addr_t mem_wr_addr [$];
    pi_word_t mem_wr_data [$];
    reg_addr_t reg_wr_addr [$];
    pi_word_t reg_wr_data [$];

    assign n64_pi_ad = ad_oe ? ad_drv : 'z;

    // Register model
    assign reg_rdata = reg_address[15:0] ^ 16'hA5A5;

    pi_bridge_top UUT (
        .clk(clk),
        .pi_reset(pi_reset),
        .n64_reset(n64_reset),
        .n64_pi_alel(alel),
        .n64_pi_aleh(aleh),
        .n64_pi_read(rd),
        .n64_pi_write(wr),
        .n64_pi_ad(n64_pi_ad),
        .window_enable(window_enable),
        .mem_req(mem_req),
        .mem_rsp(mem_rsp),
        .reg_address(reg_address),
        .reg_read(reg_read),
        .reg_write(reg_write),
        .reg_wdata(reg_wdata),
        .reg_rdata(reg_rdata),
        .last_address(last_address)
    );

    mem_bus_model u_mem (
        .clk(clk),
        .pi_reset(pi_reset),
        .mem_req(mem_req),
        .mem_rsp(mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Bus activity seen during the current row
    always @(posedge clk) begin
        if (mem_rsp.ack) begin
            mem_acks++;
            if (mem_req.write) begin
                mem_wr_addr.push_back(mem_req.address);
                mem_wr_data.push_back(mem_req.wdata);
            end
        end
        if (reg_read) begin
            reg_reads++;
        end
        if (reg_write) begin
            reg_wr_addr.push_back(reg_address);
            reg_wr_data.push_back(reg_wdata);
        end
        if (UUT.u_bus_events.pad_oe) begin
            pad_cycles++;
        end
    end

    initial begin
        repeat (ROWS * 400) @(posedge clk);
        $display("Watchdog expired before all rows were applied");
        $display("Done: errors found");
        $finish;
    end

    task automatic wait_clocks(input int n);
        repeat (n) @(posedge clk);
        #10;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic fill_table();
        // ROM burst, save write then read back, config write and read
        table_rows[0] = '{4'hF, 1'b1, 32'h1000_0010, 1'b0, 1'b0, 1'b0, 2'd3,
                          48'h3C34_3C35_3C36, 32'h0};
        table_rows[1] = '{4'hF, 1'b1, 32'h0800_0000, 1'b1, 1'b0, 1'b0, 2'd3,
                          48'h1234_BEEF_5A5A, 32'h03FE_0000};
        table_rows[2] = '{4'hF, 1'b1, 32'h0800_0000, 1'b0, 1'b0, 1'b0, 2'd3,
                          48'h1234_BEEF_5A5A, 32'h0};
        table_rows[3] = '{4'hF, 1'b1, 32'h1FFF_0040, 1'b1, 1'b1, 1'b0, 2'd2,
                          48'h1111_2222_0000, 32'h0};
        table_rows[4] = '{4'hF, 1'b1, 32'h1FFF_0080, 1'b0, 1'b1, 1'b0, 2'd2,
                          48'hA525_A527_0000, 32'h0};
        // No window, disabled save window, console held in reset
        table_rows[5] = '{4'hF, 1'b1, 32'h3000_0000, 1'b0, 1'b0, 1'b1, 2'd1,
                          48'h0, 32'h0};
        table_rows[6] = '{4'hE, 1'b1, 32'h0800_0000, 1'b0, 1'b0, 1'b1, 2'd1,
                          48'h0, 32'h0};
        table_rows[7] = '{4'hF, 1'b0, 32'h1000_0010, 1'b0, 1'b0, 1'b1, 2'd1,
                          48'h0, 32'h0};
        table_rows[8] = '{4'hF, 1'b1, 32'h1FFE_0100, 1'b0, 1'b0, 1'b0, 2'd2,
                          48'h3CBC_3CBD_0000, 32'h0};
    endtask

    task automatic run_row(input int r);
        row_t row;
        pi_word_t word;
        int err_before;
        row = table_rows[r];
        err_before = errors;
        window_enable = row.enables;
        n64_reset = row.run;
        mem_acks = 0;
        reg_reads = 0;
        pad_cycles = 0;
        mem_wr_addr.delete();
        mem_wr_data.delete();
        reg_wr_addr.delete();
        reg_wr_data.delete();
        wait_clocks(4);

        // Address latch pair followed by the valid phase
        ad_oe = 1'b1;
        ad_drv = row.addr[31:16];
        aleh = 1'b1;
        alel = 1'b1;
        wait_clocks(PHASE);
        ad_drv = row.addr[15:0];
        aleh = 1'b0;
        wait_clocks(PHASE);
        alel = 1'b0;
        ad_oe = row.is_write;
        wait_clocks(PHASE);
        if (row.run) begin
            check_value("last_address", last_address, row.addr);
        end

        for (int k = 0; k < row.words; k++) begin
            word = row.data[47 - 16 * k -: 16];
            if (row.is_write) begin
                ad_drv = word;
                wr = 1'b0;
                wait_clocks(PHASE);
                wr = 1'b1;
            end else begin
                rd = 1'b0;
                wait_clocks(PHASE);
                if (!row.quiet) begin
                    check_value("n64_pi_ad", n64_pi_ad, word);
                end
                rd = 1'b1;
            end
            wait_clocks(PHASE);
        end

        aleh = 1'b1;
        ad_oe = 1'b0;
        wait_clocks(PHASE);

        if (row.quiet) begin
            check_value("mem_rsp.ack count", mem_acks, 0);
            check_value("reg strobe count", reg_reads + reg_wr_addr.size(), 0);
            check_value("pad drive cycles", pad_cycles, 0);
        end else if (row.is_write && !row.to_reg) begin
            check_value("mem write count", mem_wr_addr.size(), row.words);
            for (int k = 0; k < mem_wr_addr.size() && k < row.words; k++) begin
                check_value("mem_req.address", mem_wr_addr[k], row.exp_mem + 2 * k);
                check_value("mem_req.wdata", mem_wr_data[k], row.data[47 - 16 * k -: 16]);
            end
        end else if (row.is_write) begin
            check_value("reg_write count", reg_wr_addr.size(), row.words);
            for (int k = 0; k < reg_wr_addr.size() && k < row.words; k++) begin
                check_value("reg_address", reg_wr_addr[k],
                            reg_addr_t'(row.addr[16:0] + 2 * k));
                check_value("reg_wdata", reg_wr_data[k], row.data[47 - 16 * k -: 16]);
            end
        end else if (row.to_reg) begin
            check_value("reg_read count", reg_reads, row.words);
        end

        n64_reset = 1'b1;
        wait_clocks(4);
        if (errors == err_before) begin
            $display("Row %0d at %h passed", r, row.addr);
        end else begin
            $display("Row %0d at %h failed with %0d errors", r, row.addr, errors - err_before);
        end
    endtask

    initial begin
        int seed_value;
        seed_value = $urandom(32'hdfa5_59bc);
        errors = 0;
        checks = 0;
        pi_reset = 1'b0;
        n64_reset = 1'b1;
        aleh = 1'b1;
        alel = 1'b0;
        rd = 1'b1;
        wr = 1'b1;
        window_enable = '0;
        ad_drv = '0;
        ad_oe = 1'b0;
        fill_table();
        wait_clocks(8);
        pi_reset = 1'b1;
        wait_clocks(4);

        for (int r = 0; r < ROWS; r++) begin
            run_row(r);
        end

        $display("Rows %0d, checks %0d, errors %0d", ROWS, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* bench/mem_bus_model.sv */
`timescale 1ns/1ps

module mem_bus_model (
    input logic clk,
    input logic pi_reset,
    input pi_pkg::mem_req_t mem_req,
    output pi_pkg::mem_rsp_t mem_rsp
);
    import pi_pkg::*;

    localparam int WORDS = 512;

    pi_word_t mem [WORDS];
    logic ack;
    logic busy;
    int wait_cnt;
    pi_word_t rdata;

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = pi_word_t'(i) ^ 16'h3C3C;
        end
    end

    // One ack per request with latency picked when the request is first seen
    always @(posedge clk) begin
        if (!pi_reset) begin
            ack <= 1'b0;
            busy <= 1'b0;
            wait_cnt <= 0;
        end else if (ack) begin
            ack <= 1'b0;
            busy <= 1'b0;
        end else if (mem_req.request) begin
            if (!busy) begin
                busy <= 1'b1;
                wait_cnt <= int'($urandom % 4);
            end else if (wait_cnt == 0) begin
                ack <= 1'b1;
                if (mem_req.write) begin
                    mem[mem_req.address[9:1]] <= mem_req.wdata;
                end else begin
                    rdata <= mem[mem_req.address[9:1]];
                end
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

    assign mem_rsp = '{ack: ack, rdata: rdata};

endmodule

/* rtl/pi_bridge_top.sv */
`timescale 1ns/1ps
`include "pi_params.svh"

module pi_bridge_top (
    input logic clk,
    input logic pi_reset,
    input logic n64_reset,
    input logic n64_pi_alel,
    input logic n64_pi_aleh,
    input logic n64_pi_read,
    input logic n64_pi_write,
    inout pi_pkg::pi_word_t n64_pi_ad,
    input logic [`PI_WINDOWS-1:0] window_enable,
    output pi_pkg::mem_req_t mem_req,
    input pi_pkg::mem_rsp_t mem_rsp,
    output pi_pkg::reg_addr_t reg_address,
    output logic reg_read,
    output logic reg_write,
    output pi_pkg::pi_word_t reg_wdata,
    input pi_pkg::pi_word_t reg_rdata,
    output pi_pkg::mem_addr_t last_address
);
    import pi_pkg::*;

    pi_events_t events;
    route_t route;
    mem_addr_t start_address;
    pi_word_t dq_out;
    logic [`PI_WINDOWS-1:0] hits;

    logic read_fifo_full;
    logic read_fifo_write;
    pi_word_t read_fifo_wdata;
    logic read_fifo_empty;
    logic read_fifo_read;
    pi_word_t read_fifo_rdata;
    logic write_fifo_full;
    logic write_fifo_write;
    pi_word_t write_fifo_wdata;
    logic write_fifo_empty;
    logic write_fifo_read;
    pi_word_t write_fifo_rdata;

    pi_bus_events u_bus_events (
        .clk(clk),
        .pi_reset(pi_reset),
        .n64_reset(n64_reset),
        .n64_pi_alel(n64_pi_alel),
        .n64_pi_aleh(n64_pi_aleh),
        .n64_pi_read(n64_pi_read),
        .n64_pi_write(n64_pi_write),
        .n64_pi_ad(n64_pi_ad),
        .route(route),
        .dq_out(dq_out),
        .events(events)
    );

    for (genvar i = 0; i < `PI_WINDOWS; i++) begin : g_window
        window_match u_match (
            .clk(clk),
            .pi_reset(pi_reset),
            .window(WINDOW_TABLE[i]),
            .enable(window_enable[i]),
            .dq_in(events.dq_in),
            .hit(hits[i])
        );
    end

    window_select u_select (
        .clk(clk),
        .pi_reset(pi_reset),
        .hits(hits),
        .events(events),
        .route(route),
        .start_address(start_address),
        .last_address(last_address)
    );

    // Prefetched words are stale once a new address is latched
    pi_fifo u_read_fifo (
        .clk(clk),
        .pi_reset(pi_reset),
        .flush(events.alel_op),
        .write(read_fifo_write),
        .wdata(read_fifo_wdata),
        .full(read_fifo_full),
        .read(read_fifo_read),
        .rdata(read_fifo_rdata),
        .empty(read_fifo_empty)
    );

    pi_fifo u_write_fifo (
        .clk(clk),
        .pi_reset(pi_reset),
        .flush(1'b0),
        .write(write_fifo_write),
        .wdata(write_fifo_wdata),
        .full(write_fifo_full),
        .read(write_fifo_read),
        .rdata(write_fifo_rdata),
        .empty(write_fifo_empty)
    );

    pi_data_path u_data_path (
        .clk(clk),
        .pi_reset(pi_reset),
        .events(events),
        .route(route),
        .start_address(start_address),
        .read_fifo_full(read_fifo_full),
        .read_fifo_write(read_fifo_write),
        .read_fifo_wdata(read_fifo_wdata),
        .read_fifo_empty(read_fifo_empty),
        .read_fifo_read(read_fifo_read),
        .read_fifo_rdata(read_fifo_rdata),
        .write_fifo_full(write_fifo_full),
        .write_fifo_write(write_fifo_write),
        .write_fifo_wdata(write_fifo_wdata),
        .write_fifo_empty(write_fifo_empty),
        .write_fifo_read(write_fifo_read),
        .write_fifo_rdata(write_fifo_rdata),
        .mem_req(mem_req),
        .mem_rsp(mem_rsp),
        .reg_address(reg_address),
        .reg_read(reg_read),
        .reg_write(reg_write),
        .reg_wdata(reg_wdata),
        .reg_rdata(reg_rdata),
        .dq_out(dq_out)
    );

endmodule

/* rtl/pi_data_path.sv */
`timescale 1ns/1ps
`include "pi_params.svh"

module pi_data_path (
    input logic clk,
    input logic pi_reset,
    input pi_pkg::pi_events_t events,
    input pi_pkg::route_t route,
    input pi_pkg::mem_addr_t start_address,
    input logic read_fifo_full,
    output logic read_fifo_write,
    output pi_pkg::pi_word_t read_fifo_wdata,
    input logic read_fifo_empty,
    output logic read_fifo_read,
    input pi_pkg::pi_word_t read_fifo_rdata,
    input logic write_fifo_full,
    output logic write_fifo_write,
    output pi_pkg::pi_word_t write_fifo_wdata,
    input logic write_fifo_empty,
    output logic write_fifo_read,
    input pi_pkg::pi_word_t write_fifo_rdata,
    output pi_pkg::mem_req_t mem_req,
    input pi_pkg::mem_rsp_t mem_rsp,
    output pi_pkg::reg_addr_t reg_address,
    output logic reg_read,
    output logic reg_write,
    output pi_pkg::pi_word_t reg_wdata,
    input pi_pkg::pi_word_t reg_rdata,
    output pi_pkg::pi_word_t dq_out
);
    import pi_pkg::*;

    logic read_wait;
    logic read_take;
    logic read_enabled;
    logic write_pending;
    logic write_late;
    pi_word_t write_hold;
    logic load_start;
    logic first_write;
    logic issue_write;
    logic issue_read;
    logic mem_request;
    logic mem_write;
    mem_addr_t mem_address;
    pi_word_t mem_wdata;

    // A read op on an empty read FIFO waits for the next word
    assign read_take = (route.read_port == PORT_MEM) && !read_fifo_empty
                       && (events.read_op || read_wait);
    assign read_fifo_read = read_take;
    assign read_fifo_write = !mem_write && mem_rsp.ack;
    assign read_fifo_wdata = mem_rsp.rdata;

    always_ff @(posedge clk) begin
        if (read_take) begin
            dq_out <= read_fifo_rdata;
        end else if (events.read_op && (route.read_port == PORT_REG)) begin
            dq_out <= reg_rdata;
        end
    end

    // A full write FIFO parks the word in write_hold
    assign write_late = write_pending && !write_fifo_full;
    assign write_fifo_write = write_late || (events.write_op && (route.write_port == PORT_MEM)
                              && !write_fifo_full && !write_pending);
    assign write_fifo_wdata = write_pending ? write_hold : events.dq_in;

    always_ff @(posedge clk) begin
        if (events.write_op) begin
            write_hold <= events.dq_in;
        end
    end

    // Queued writes go ahead of read prefetch
    assign issue_write = !mem_request && (route.write_port == PORT_MEM) && !write_fifo_empty;
    assign issue_read = !mem_request && !issue_write && (route.read_port == PORT_MEM)
                        && read_enabled && !read_fifo_full;
    assign write_fifo_read = issue_write;

    always_ff @(posedge clk) begin
        if (!pi_reset) begin
            read_wait <= 1'b0;
            write_pending <= 1'b0;
            load_start <= 1'b0;
            read_enabled <= 1'b0;
            first_write <= 1'b0;
            mem_request <= 1'b0;
        end else begin
            load_start <= events.alel_op;
            if (events.alel_op || read_take) begin
                read_wait <= 1'b0;
            end else if (events.read_op && (route.read_port == PORT_MEM)) begin
                read_wait <= 1'b1;
            end
            if (write_late) begin
                write_pending <= 1'b0;
            end
            if (events.write_op && (route.write_port == PORT_MEM) && write_fifo_full) begin
                write_pending <= 1'b1;
            end
            if (events.alel_op) begin
                read_enabled <= 1'b1;
                first_write <= 1'b1;
            end
            if (mem_rsp.ack) begin
                mem_request <= 1'b0;
            end
            if (issue_write || issue_read) begin
                mem_request <= 1'b1;
            end
            if (issue_write) begin
                first_write <= 1'b0;
            end
            if (issue_write || events.end_op) begin
                read_enabled <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_rsp.ack) begin
            mem_address <= mem_address + 2'd2;
        end
        if (load_start) begin
            mem_address <= start_address;
        end
        if (issue_write) begin
            mem_write <= 1'b1;
            mem_wdata <= write_fifo_rdata;
            // Prefetch may have moved the address past the burst start
            if (first_write) begin
                mem_address <= start_address;
            end
        end else if (issue_read) begin
            mem_write <= 1'b0;
        end
    end

    assign mem_req = '{request: mem_request, write: mem_write,
                       address: mem_address, wdata: mem_wdata};

    // Register bus
    always_ff @(posedge clk) begin
        if (events.aleh_op) begin
            reg_address[`PI_REG_ADDR_W-1] <= events.dq_in[0];
        end
        if (events.alel_op) begin
            reg_address[15:0] <= events.dq_in;
        end
        if (events.read_op || events.write_op) begin
            reg_address <= reg_address + 2'd2;
        end
    end

    assign reg_read = events.read_op && (route.read_port == PORT_REG);
    assign reg_write = events.write_op && (route.write_port == PORT_REG);
    assign reg_wdata = events.dq_in;

endmodule

/* rtl/pi_fifo.sv */
`timescale 1ns/1ps
`include "pi_params.svh"

module pi_fifo (
    input logic clk,
    input logic pi_reset,
    input logic flush,
    input logic write,
    input pi_pkg::pi_word_t wdata,
    output logic full,
    input logic read,
    output pi_pkg::pi_word_t rdata,
    output logic empty
);
    import pi_pkg::*;

    localparam int PTR_W = $clog2(`PI_FIFO_DEPTH);

    pi_word_t mem [`PI_FIFO_DEPTH];
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;

    always_ff @(posedge clk) begin
        if (write && !full) begin
            mem[wr_ptr[PTR_W-1:0]] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!pi_reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (write && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (read && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Extra pointer bit tells full from empty
    assign empty = (wr_ptr == rd_ptr);
    assign full = (wr_ptr[PTR_W] != rd_ptr[PTR_W])
                  && (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    // Head word is visible without a read
    assign rdata = mem[rd_ptr[PTR_W-1:0]];

endmodule

/* decode/window_select.sv */
`timescale 1ns/1ps
`include "pi_params.svh"

module window_select (
    input logic clk,
    input logic pi_reset,
    input logic [`PI_WINDOWS-1:0] hits,
    input pi_pkg::pi_events_t events,
    output pi_pkg::route_t route,
    output pi_pkg::mem_addr_t start_address,
    output pi_pkg::mem_addr_t last_address
);
    import pi_pkg::*;

    localparam int SEL_W = (`PI_WINDOWS > 1) ? $clog2(`PI_WINDOWS) : 1;
    localparam route_t ROUTE_NONE = '{
        read_port: PORT_NONE,
        write_port: PORT_NONE,
        offset: '0
    };

    logic hit_any;
    logic [SEL_W-1:0] hit_index;

    // Later table entries override earlier ones
    always_comb begin
        hit_any = 1'b0;
        hit_index = '0;
        for (int i = 0; i < `PI_WINDOWS; i++) begin
            if (hits[i]) begin
                hit_any = 1'b1;
                hit_index = SEL_W'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!pi_reset) begin
            route <= ROUTE_NONE;
        end else if (events.aleh_op) begin
            if (hit_any) begin
                route.read_port <= WINDOW_TABLE[hit_index].read_port;
                route.write_port <= WINDOW_TABLE[hit_index].write_port;
                route.offset <= WINDOW_TABLE[hit_index].offset;
            end else begin
                route <= ROUTE_NONE;
            end
        end
    end

    // Upper half held here also feeds the start address
    always_ff @(posedge clk) begin
        if (events.aleh_op) begin
            last_address[31:16] <= events.dq_in;
        end
        if (events.alel_op) begin
            last_address[15:0] <= events.dq_in;
            start_address <= {last_address[31:16], events.dq_in} + route.offset;
        end
    end

endmodule

/* decode/window_match.sv */
`timescale 1ns/1ps

module window_match (
    input logic clk,
    input logic pi_reset,
    input pi_pkg::window_t window,
    input logic enable,
    input pi_pkg::pi_word_t dq_in,
    output logic hit
);

    logic enable_q;
    logic in_range;

    // Enable comes from a slow config domain
    always_ff @(posedge clk) begin
        if (!pi_reset) begin
            enable_q <= 1'b0;
        end else begin
            enable_q <= enable;
        end
    end

    // Half-open range on the upper address half
    assign in_range = (dq_in >= window.base_hi) && (dq_in < window.limit_hi);

    assign hit = enable_q && in_range;

endmodule

/* rtl/pi_bus_events.sv */
`timescale 1ns/1ps
`include "pi_params.svh"

module pi_bus_events (
    input logic clk,
    input logic pi_reset,
    input logic n64_reset,
    input logic n64_pi_alel,
    input logic n64_pi_aleh,
    input logic n64_pi_read,
    input logic n64_pi_write,
    inout pi_pkg::pi_word_t n64_pi_ad,
    input pi_pkg::route_t route,
    input pi_pkg::pi_word_t dq_out,
    output pi_pkg::pi_events_t events
);
    import pi_pkg::*;

    localparam int RESET_SYNC = 2;

    logic [RESET_SYNC-1:0] reset_ff;
    logic [`PI_ALE_SYNC-1:0] aleh_ff;
    logic [`PI_ALE_SYNC-1:0] alel_ff;
    logic [`PI_READ_SYNC-1:0] read_ff;
    logic [`PI_WRITE_SYNC-1:0] write_ff;

    logic bus_run;
    logic read_s;
    logic write_s;
    e_pi_mode mode;
    e_pi_mode last_mode;
    logic last_read;
    logic last_write;
    logic pad_oe;
    pi_word_t dq_in;

    // Chains start from the idle pin levels
    always_ff @(posedge clk) begin
        if (!pi_reset) begin
            reset_ff <= '0;
            aleh_ff <= '1;
            alel_ff <= '0;
            read_ff <= '1;
            write_ff <= '1;
        end else begin
            reset_ff <= {reset_ff[RESET_SYNC-2:0], n64_reset};
            aleh_ff <= {aleh_ff[`PI_ALE_SYNC-2:0], n64_pi_aleh};
            alel_ff <= {alel_ff[`PI_ALE_SYNC-2:0], n64_pi_alel};
            read_ff <= {read_ff[`PI_READ_SYNC-2:0], n64_pi_read};
            write_ff <= {write_ff[`PI_WRITE_SYNC-2:0], n64_pi_write};
        end
    end

    assign bus_run = reset_ff[RESET_SYNC-1];
    assign read_s = read_ff[`PI_READ_SYNC-1];
    assign write_s = write_ff[`PI_WRITE_SYNC-1];
    assign mode = e_pi_mode'({aleh_ff[`PI_ALE_SYNC-1], alel_ff[`PI_ALE_SYNC-1]});

    always_ff @(posedge clk) begin
        if (!pi_reset) begin
            last_mode <= PI_MODE_IDLE;
            last_read <= 1'b1;
            last_write <= 1'b1;
            pad_oe <= 1'b0;
        end else begin
            last_mode <= mode;
            last_read <= read_s;
            last_write <= write_s;
            // Drive while the console holds read low on a readable window
            pad_oe <= bus_run && (mode == PI_MODE_VALID) && !read_s
                      && (route.read_port != PORT_NONE);
        end
    end

    always_ff @(posedge clk) begin
        dq_in <= n64_pi_ad;
    end

    assign n64_pi_ad = pad_oe ? dq_out : 'z;

    always_comb begin
        events.aleh_op = bus_run && (last_mode != PI_MODE_HIGH) && (mode == PI_MODE_HIGH);
        events.alel_op = bus_run && (last_mode == PI_MODE_HIGH) && (mode == PI_MODE_LOW);
        events.read_op = bus_run && (mode == PI_MODE_VALID) && (route.read_port != PORT_NONE)
                         && last_read && !read_s;
        events.write_op = bus_run && (mode == PI_MODE_VALID) && (route.write_port != PORT_NONE)
                          && last_write && !write_s;
        events.end_op = bus_run && (last_mode == PI_MODE_VALID) && (mode != PI_MODE_VALID);
        events.dq_in = dq_in;
    end

endmodule

/* common/pi_pkg.sv */
`include "pi_params.svh"

package pi_pkg;

    typedef logic [`PI_DATA_W-1:0] pi_word_t;
    typedef logic [`PI_ADDR_W-1:0] mem_addr_t;
    typedef logic [`PI_REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [1:0] {
        PORT_NONE,
        PORT_MEM,
        PORT_REG
    } e_port;

    // Encoded as {aleh, alel}
    typedef enum logic [1:0] {
        PI_MODE_IDLE  = 2'b10,
        PI_MODE_HIGH  = 2'b11,
        PI_MODE_LOW   = 2'b01,
        PI_MODE_VALID = 2'b00
    } e_pi_mode;

    // Upper address half range is [base_hi, limit_hi)
    typedef struct packed {
        pi_word_t base_hi;
        pi_word_t limit_hi;
        mem_addr_t offset;
        e_port read_port;
        e_port write_port;
    } window_t;

    localparam window_t WINDOW_TABLE [`PI_WINDOWS] = '{
        // Save memory
        '{base_hi: 16'h0800, limit_hi: 16'h0802, offset: 32'h03FE_0000 - 32'h0800_0000,
          read_port: PORT_MEM, write_port: PORT_MEM},
        // ROM
        '{base_hi: 16'h1000, limit_hi: 16'h1400, offset: 32'h0000_0000 - 32'h1000_0000,
          read_port: PORT_MEM, write_port: PORT_MEM},
        // Transfer buffer
        '{base_hi: 16'h1FFE, limit_hi: 16'h1FFF, offset: 32'h0500_0000 - 32'h1FFE_0000,
          read_port: PORT_MEM, write_port: PORT_MEM},
        // Config registers
        '{base_hi: 16'h1FFF, limit_hi: 16'h2000, offset: 32'h0000_0000,
          read_port: PORT_REG, write_port: PORT_REG}
    };

    typedef struct packed {
        logic aleh_op;
        logic alel_op;
        logic read_op;
        logic write_op;
        logic end_op;
        pi_word_t dq_in;
    } pi_events_t;

    typedef struct packed {
        logic request;
        logic write;
        mem_addr_t address;
        pi_word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic ack;
        pi_word_t rdata;
    } mem_rsp_t;

    typedef struct packed {
        e_port read_port;
        e_port write_port;
        mem_addr_t offset;
    } route_t;

endpackage

/* common/pi_params.svh */
`ifndef PI_PARAMS_SVH
`define PI_PARAMS_SVH

// Console bus word and memory byte address
`define PI_DATA_W 16
`define PI_ADDR_W 32

// Register bus byte address
`define PI_REG_ADDR_W 17

// Decoded address windows
`define PI_WINDOWS 4

// Words per FIFO as a power of two
`define PI_FIFO_DEPTH 4

// Synchronizer stages per pin group
`define PI_ALE_SYNC 4
`define PI_READ_SYNC 2
`define PI_WRITE_SYNC 3

`endif
